// File: logic/sensor_bridge_pkg.sv
package sensor_bridge_pkg;

    localparam int DATA_W     = 32;  // Bus data and sample width
    localparam int ADDR_W     = 17;  // Byte address into the aperture
    localparam int REGION_LSB = 12;  // Lowest bit of the region field
    localparam int LEVEL_W    = 4;   // Holds 0..FIFO_DEPTH for depths up to 8

    typedef logic [DATA_W-1:0] sample_t;

    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [3:0]        sel;
        logic              we;
        logic              cyc;
        logic              stb;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
    } wb_rsp_t;

    typedef struct packed {
        logic sensor_en;
        logic fifo_flush;   // Single-cycle pulse
    } ctrl_t;

    typedef struct packed {
        logic [LEVEL_W-1:0] level;
        logic               empty;
        logic               full;
        logic               overrun;  // Sticky
    } fifo_stat_t;

    // Aperture map, byte addresses
    localparam logic [ADDR_W-1:0] REG_BASE   = 17'h00000;
    localparam logic [ADDR_W-1:0] DPORT_BASE = 17'h11000;
    localparam logic [ADDR_W-1:0] RSVD_BASE  = 17'h12000;

    // Byte offsets inside the register region
    localparam logic [REGION_LSB-1:0] REG_ID        = 12'h000;
    localparam logic [REGION_LSB-1:0] REG_REV       = 12'h004;
    localparam logic [REGION_LSB-1:0] REG_FIFO_RST  = 12'h008;
    localparam logic [REGION_LSB-1:0] REG_SENSOR_EN = 12'h00C;
    localparam logic [REGION_LSB-1:0] REG_OVERRUN   = 12'h010;
    localparam logic [REGION_LSB-1:0] REG_LEVEL     = 12'h014;

    localparam logic [REGION_LSB-1:0] RSVD_CUST_PROD = 12'h1F8;
    localparam logic [REGION_LSB-1:0] RSVD_REVISIONS = 12'h1FC;

    localparam logic [DATA_W-1:0] DEVICE_ID        = 32'h0000_5E50;
    localparam logic [DATA_W-1:0] REV_LEVEL        = 32'h0000_0100;
    localparam logic [DATA_W-1:0] CUST_PROD_VALUE  = 32'h0000_0100;
    localparam logic [DATA_W-1:0] REVISIONS_VALUE  = 32'h0001_0000;
    localparam logic [DATA_W-1:0] DEF_REG_VALUE    = 32'hFABDEFAC;
    localparam logic [DATA_W-1:0] RSVD_DEF_VALUE   = 32'hDEFFABAC;
    localparam logic [DATA_W-1:0] BAD_ACCESS_VALUE = 32'hBADFABAC;

endpackage

// File: logic/spi_sample_reader.sv
module spi_sample_reader #(
    parameter int SCLK_DIV  = 2,
    parameter int FRAME_GAP = 4
) (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  sensor_bridge_pkg::ctrl_t   ctrl_i,
    output logic                       cs_n_o,
    output logic                       sclk_o,
    input  logic                       sdata_i,
    output logic                       push_o,
    output sensor_bridge_pkg::sample_t sample_o
);

    localparam int DIV_W = $clog2(SCLK_DIV + 1);
    localparam int GAP_W = $clog2(FRAME_GAP + 1);
    localparam int BIT_W = $clog2(sensor_bridge_pkg::DATA_W + 1);

    localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(SCLK_DIV - 1);
    localparam logic [GAP_W-1:0] GAP_LAST  = GAP_W'(FRAME_GAP - 1);
    localparam logic [BIT_W-1:0] BITS_FULL = BIT_W'(sensor_bridge_pkg::DATA_W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_GAP
    } state_t;

    state_t                     state;
    logic [DIV_W-1:0]           div_cnt;
    logic [GAP_W-1:0]           gap_cnt;
    logic [BIT_W-1:0]           bit_cnt;   // Rising edges seen in this frame
    sensor_bridge_pkg::sample_t shreg;
    logic                       half_done;
    logic                       frame_start;

    assign half_done   = (div_cnt == DIV_LAST);
    // A new frame starts from idle, or straight out of the gap
    assign frame_start = ctrl_i.sensor_en &&
                         (state == ST_IDLE || (state == ST_GAP && gap_cnt == GAP_LAST));

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            state   <= ST_IDLE;
            cs_n_o  <= 1'b1;
            sclk_o  <= 1'b0;
            div_cnt <= '0;
            gap_cnt <= '0;
            bit_cnt <= '0;
            push_o  <= 1'b0;
        end
        else
        begin
            push_o <= 1'b0;
            if (frame_start)
            begin
                state   <= ST_SHIFT;
                cs_n_o  <= 1'b0;
                div_cnt <= '0;
                bit_cnt <= '0;
            end
            else
            begin
                case (state)
                    ST_SHIFT:
                    begin
                        div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                        if (half_done)
                        begin
                            sclk_o <= ~sclk_o;
                            if (!sclk_o)
                                bit_cnt <= bit_cnt + 1'b1;
                            else if (bit_cnt == BITS_FULL)
                            begin
                                // Last falling edge closes the frame
                                state   <= ST_GAP;
                                cs_n_o  <= 1'b1;
                                push_o  <= 1'b1;
                                gap_cnt <= '0;
                            end
                        end
                    end
                    ST_GAP:
                        if (gap_cnt == GAP_LAST)
                            state <= ST_IDLE;  // Enable was cleared
                        else
                            gap_cnt <= gap_cnt + 1'b1;
                    default:
                        state <= ST_IDLE;
                endcase
            end
        end
    end

    // MSB first, taken as sclk goes high
    always_ff @(posedge wb_clk_i)
    begin
        if (state == ST_SHIFT && half_done && !sclk_o)
            shreg <= {shreg[sensor_bridge_pkg::DATA_W-2:0], sdata_i};
    end

    assign sample_o = shreg;   // Stable through the gap

    // Serial clock only runs inside a frame
    a_sclk_in_frame: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $changed(sclk_o) |-> !$past(cs_n_o));

endmodule

// File: logic/sample_fifo.sv
module sample_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          wb_clk_i,
    input  logic                          rst_i,
    input  logic                          push_i,
    input  sensor_bridge_pkg::sample_t    sample_i,
    input  logic                          pop_i,
    input  sensor_bridge_pkg::ctrl_t      ctrl_i,
    input  logic                          ovr_clr_i,
    output sensor_bridge_pkg::sample_t    head_o,
    output sensor_bridge_pkg::fifo_stat_t stat_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int LVL_W = sensor_bridge_pkg::LEVEL_W;
    localparam logic [LVL_W-1:0] FULL_LEVEL = FIFO_DEPTH[LVL_W-1:0];

    generate
        if (FIFO_DEPTH >= (1 << LVL_W))
            $error("FIFO_DEPTH does not fit the level field");
    endgenerate

    sensor_bridge_pkg::sample_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [LVL_W-1:0]           level;
    logic                       overrun;
    logic                       full;
    logic                       empty;
    logic                       do_push;
    logic                       do_pop;

    assign full    = (level == FULL_LEVEL);
    assign empty   = (level == '0);
    assign do_push = push_i && !full;   // Dropped when full
    assign do_pop  = pop_i && !empty;

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i || ctrl_i.fifo_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // Flush leaves the overrun flag alone
    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
            overrun <= 1'b0;
        else if (push_i && full)
            overrun <= 1'b1;
        else if (ovr_clr_i)
            overrun <= 1'b0;
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (do_push)
            mem[wr_ptr] <= sample_i;
    end

    assign head_o         = mem[rd_ptr];
    assign stat_o.level   = level;
    assign stat_o.empty   = empty;
    assign stat_o.full    = full;
    assign stat_o.overrun = overrun;

    // Level stays in range and matches the pointer distance
    a_level_bound: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        level <= FULL_LEVEL && level[PTR_W-1:0] == wr_ptr - rd_ptr);

endmodule

// File: logic/wb_reg_bank.sv
module wb_reg_bank (
    input  logic                          wb_clk_i,
    input  logic                          rst_i,
    input  sensor_bridge_pkg::wb_req_t    wb_req_i,
    input  logic                          reg_sel_i,
    input  logic                          dport_sel_i,
    output sensor_bridge_pkg::sample_t    dat_o,
    output logic                          ack_o,
    output sensor_bridge_pkg::ctrl_t      ctrl_o,
    input  sensor_bridge_pkg::fifo_stat_t fifo_stat_i,
    input  sensor_bridge_pkg::sample_t    fifo_dat_i,
    output logic                          pop_o,
    output logic                          ovr_clr_o
);

    localparam int PAD_W = sensor_bridge_pkg::DATA_W - sensor_bridge_pkg::LEVEL_W;

    logic [sensor_bridge_pkg::REGION_LSB-1:0] offset;
    logic                                     wr_lane0;
    sensor_bridge_pkg::sample_t               reg_word;

    assign offset = wb_req_i.adr[sensor_bridge_pkg::REGION_LSB-1:0];

    // Write strobe for byte lane 0, once per transfer
    assign wr_lane0 = reg_sel_i && wb_req_i.stb && wb_req_i.we && !ack_o && wb_req_i.sel[0];

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
            ack_o <= 1'b0;
        else
            ack_o <= (reg_sel_i || dport_sel_i) && wb_req_i.stb && !ack_o;
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            ctrl_o.sensor_en  <= 1'b0;
            ctrl_o.fifo_flush <= 1'b0;
            ovr_clr_o         <= 1'b0;
        end
        else
        begin
            if (wr_lane0 && offset == sensor_bridge_pkg::REG_SENSOR_EN)
                ctrl_o.sensor_en <= wb_req_i.dat[0];
            ctrl_o.fifo_flush <= wr_lane0 && wb_req_i.dat[0] &&
                                 offset == sensor_bridge_pkg::REG_FIFO_RST;
            ovr_clr_o <= wr_lane0 && wb_req_i.dat[0] &&
                         offset == sensor_bridge_pkg::REG_OVERRUN;  // Write 1 to clear
        end
    end

    always_comb
    begin
        case (offset)
            sensor_bridge_pkg::REG_ID:
                reg_word = sensor_bridge_pkg::DEVICE_ID;
            sensor_bridge_pkg::REG_REV:
                reg_word = sensor_bridge_pkg::REV_LEVEL;
            sensor_bridge_pkg::REG_FIFO_RST:
                reg_word = '0;   // Write-only pulse
            sensor_bridge_pkg::REG_SENSOR_EN:
                reg_word = {{(sensor_bridge_pkg::DATA_W-1){1'b0}}, ctrl_o.sensor_en};
            sensor_bridge_pkg::REG_OVERRUN:
                reg_word = {{(sensor_bridge_pkg::DATA_W-1){1'b0}}, fifo_stat_i.overrun};
            sensor_bridge_pkg::REG_LEVEL:
                reg_word = {{PAD_W{1'b0}}, fifo_stat_i.level};
            default:
                reg_word = sensor_bridge_pkg::DEF_REG_VALUE;
        endcase
    end

    // Data port shows the FIFO head, zero when nothing is queued
    always_comb
    begin
        if (dport_sel_i)
            dat_o = fifo_stat_i.empty ? '0 : fifo_dat_i;
        else
            dat_o = reg_word;
    end

    // Head moves on at the end of the ack cycle
    assign pop_o = ack_o && dport_sel_i && !wb_req_i.we && !fifo_stat_i.empty;

    a_no_pop_empty: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        pop_o |-> fifo_stat_i.level != '0);

endmodule

// File: logic/wb_addr_decode.sv
module wb_addr_decode #(
    parameter int TIMEOUT_CYCLES = 7
) (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  sensor_bridge_pkg::wb_req_t wb_req_i,
    output sensor_bridge_pkg::wb_rsp_t wb_rsp_o,
    output logic                       reg_sel_o,
    output logic                       dport_sel_o,
    input  sensor_bridge_pkg::sample_t reg_dat_i,
    input  logic                       reg_ack_i
);

    localparam int AW    = sensor_bridge_pkg::ADDR_W;
    localparam int RL    = sensor_bridge_pkg::REGION_LSB;
    localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

    localparam logic [AW-RL-1:0] REG_RGN   = sensor_bridge_pkg::REG_BASE[AW-1:RL];
    localparam logic [AW-RL-1:0] DPORT_RGN = sensor_bridge_pkg::DPORT_BASE[AW-1:RL];
    localparam logic [AW-RL-1:0] RSVD_RGN  = sensor_bridge_pkg::RSVD_BASE[AW-1:RL];
    localparam logic [TMO_W-1:0] TMO_LAST  = TMO_W'(TIMEOUT_CYCLES - 1);

    logic [AW-RL-1:0]           region;
    logic                       rsvd_sel;
    logic                       bad_req;
    logic                       rsvd_ack;
    logic                       bad_ack;
    logic [TMO_W-1:0]           tmo_cnt;
    sensor_bridge_pkg::sample_t rsvd_dat;

    assign region      = wb_req_i.adr[AW-1:RL];
    assign reg_sel_o   = wb_req_i.cyc && region == REG_RGN;
    assign dport_sel_o = wb_req_i.cyc && region == DPORT_RGN;
    assign rsvd_sel    = wb_req_i.cyc && region == RSVD_RGN;
    assign bad_req     = wb_req_i.cyc && wb_req_i.stb && !reg_sel_o && !dport_sel_o && !rsvd_sel;

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            rsvd_ack <= 1'b0;
            bad_ack  <= 1'b0;
            tmo_cnt  <= '0;
        end
        else
        begin
            rsvd_ack <= rsvd_sel && wb_req_i.stb && !rsvd_ack;
            bad_ack  <= 1'b0;
            if (!bad_req || bad_ack)
                tmo_cnt <= '0;   // Idle, or transfer just ended
            else if (tmo_cnt == TMO_LAST)
                bad_ack <= 1'b1;
            else
                tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    // Fixed ID words
    always_comb
    begin
        case (wb_req_i.adr[RL-1:0])
            sensor_bridge_pkg::RSVD_CUST_PROD: rsvd_dat = sensor_bridge_pkg::CUST_PROD_VALUE;
            sensor_bridge_pkg::RSVD_REVISIONS: rsvd_dat = sensor_bridge_pkg::REVISIONS_VALUE;
            default:                           rsvd_dat = sensor_bridge_pkg::RSVD_DEF_VALUE;
        endcase
    end

    always_comb
    begin
        case (region)
            REG_RGN, DPORT_RGN: wb_rsp_o.dat = reg_dat_i;
            RSVD_RGN:           wb_rsp_o.dat = rsvd_dat;
            default:            wb_rsp_o.dat = sensor_bridge_pkg::BAD_ACCESS_VALUE;
        endcase
        wb_rsp_o.ack = reg_ack_i || rsvd_ack || bad_ack;
    end

    // Single-cycle ack across all responders
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        wb_rsp_o.ack |=> !wb_rsp_o.ack);

endmodule

// File: logic/sensor_bridge_top.sv
module sensor_bridge_top #(
    parameter int FIFO_DEPTH     = 8,
    parameter int SCLK_DIV       = 2,
    parameter int FRAME_GAP      = 4,
    parameter int TIMEOUT_CYCLES = 7
) (
    input  logic                       wb_clk_i,
    input  logic                       rst_i,
    input  sensor_bridge_pkg::wb_req_t wb_req_i,
    output sensor_bridge_pkg::wb_rsp_t wb_rsp_o,
    output logic                       cs_n_o,
    output logic                       sclk_o,
    input  logic                       sdata_i
);

    logic                          reg_sel;
    logic                          dport_sel;
    logic                          reg_ack;
    logic                          pop;
    logic                          push;
    logic                          ovr_clr;
    sensor_bridge_pkg::sample_t    reg_dat;
    sensor_bridge_pkg::sample_t    fifo_head;
    sensor_bridge_pkg::sample_t    sample;
    sensor_bridge_pkg::ctrl_t      ctrl;
    sensor_bridge_pkg::fifo_stat_t fifo_stat;

    wb_addr_decode #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_wb_addr_decode (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
        .reg_sel_o(reg_sel), .dport_sel_o(dport_sel),
        .reg_dat_i(reg_dat), .reg_ack_i(reg_ack)
    );

    wb_reg_bank u_wb_reg_bank (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i), .wb_req_i(wb_req_i),
        .reg_sel_i(reg_sel), .dport_sel_i(dport_sel),
        .dat_o(reg_dat), .ack_o(reg_ack), .ctrl_o(ctrl),
        .fifo_stat_i(fifo_stat), .fifo_dat_i(fifo_head),
        .pop_o(pop), .ovr_clr_o(ovr_clr)
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_sample_fifo (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .push_i(push), .sample_i(sample), .pop_i(pop),
        .ctrl_i(ctrl), .ovr_clr_i(ovr_clr),
        .head_o(fifo_head), .stat_o(fifo_stat)
    );

    spi_sample_reader #(.SCLK_DIV(SCLK_DIV), .FRAME_GAP(FRAME_GAP)) u_spi_sample_reader (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i), .ctrl_i(ctrl),
        .cs_n_o(cs_n_o), .sclk_o(sclk_o), .sdata_i(sdata_i),
        .push_o(push), .sample_o(sample)
    );

endmodule

// File: test/spi_sensor_model.sv
module spi_sensor_model #(
    parameter logic [15:0] SEED = 16'd30333
) (
    input  logic cs_n_i,
    input  logic sclk_i,
    output logic sdata_o
);

    logic [15:0] lfsr_state = SEED;
    logic [31:0] word;
    logic [31:0] word_log [$];   // Every frame's word in send order

    // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    initial
    begin
        sdata_o = 1'b0;
        word    = '0;
        forever
        begin
            @(negedge cs_n_i);
            for (int b = 0; b < 32; b++)
            begin
                word       = {word[30:0], lfsr_state[0]};   // One step per bit
                lfsr_state = lfsr_step(lfsr_state);
            end
            word_log.push_back(word);
            sdata_o = word[31];   // MSB ready before the first rising sclk
            for (int i = 30; i >= 0; i--)
            begin
                @(negedge sclk_i);
                sdata_o = word[i];
            end
        end
    end

endmodule

// File: test/tb_sensor_bridge.sv
module tb_sensor_bridge;

    localparam int FIFO_DEPTH     = 8;
    localparam int SCLK_DIV       = 2;
    localparam int FRAME_GAP      = 4;
    localparam int TIMEOUT_CYCLES = 7;
    localparam int ACK_LIMIT      = TIMEOUT_CYCLES + 1;
    localparam int FRAME_CYCLES   = 2 * SCLK_DIV * 32 + FRAME_GAP + 4;
    localparam int WAIT_LIMIT     = (FIFO_DEPTH + 2) * FRAME_CYCLES;   // Longest single wait

    localparam logic [16:0] A_ID     = 17'h00000;
    localparam logic [16:0] A_REV    = 17'h00004;
    localparam logic [16:0] A_FRST   = 17'h00008;
    localparam logic [16:0] A_EN     = 17'h0000C;
    localparam logic [16:0] A_OVR    = 17'h00010;
    localparam logic [16:0] A_LEVEL  = 17'h00014;
    localparam logic [16:0] A_DPORT  = 17'h11000;
    localparam logic [31:0] BAD_WORD = 32'hBADF_ABAC;

    typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_WAIT, OP_QUIET} op_t;

    typedef struct packed {
        op_t         op;
        logic [16:0] addr;
        logic [31:0] wdata;        // Quiet cycles for OP_QUIET
        logic [31:0] exp_val;
        logic        from_model;   // Expected word comes from the sensor model
    } step_t;

    logic                       clk;
    logic                       rst;
    sensor_bridge_pkg::wb_req_t wb_req;
    sensor_bridge_pkg::wb_rsp_t wb_rsp;
    logic                       cs_n;
    logic                       sclk;
    logic                       sdata;
    step_t                      steps [$];
    int                         errors       = 0;
    int                         checks       = 0;
    int                         cycles       = 0;
    int                         cycle_limit  = 0;
    int                         model_idx    = 0;
    logic                       link_may_run = 1'b0;
    logic                       link_flagged = 1'b0;
    logic                       sclk_flagged = 1'b0;

    sensor_bridge_top #(
        .FIFO_DEPTH(FIFO_DEPTH), .SCLK_DIV(SCLK_DIV),
        .FRAME_GAP(FRAME_GAP), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) DUT (
        .wb_clk_i(clk), .rst_i(rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
        .cs_n_o(cs_n), .sclk_o(sclk), .sdata_i(sdata)
    );

    spi_sensor_model #(.SEED(16'd30333)) sensor (.cs_n_i(cs_n), .sclk_i(sclk), .sdata_o(sdata));

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cycles <= cycles + 1;

    // Link must stay idle whenever capture was never enabled or has drained
    always @(negedge clk)
    begin
        if (!rst && !link_may_run && !link_flagged && cs_n !== 1'b1)
        begin
            $display("Chip select went low while capture was disabled");
            errors++;
            link_flagged = 1'b1;
        end
        if (!rst && !sclk_flagged && cs_n === 1'b1 && sclk !== 1'b0)   // Rests low between frames
        begin
            $display("Serial clock was not low while chip select was high");
            errors++;
            sclk_flagged = 1'b1;
        end
    end

    initial
    begin
        wait (cycle_limit > 0);
        wait (cycles >= cycle_limit);
        $display("Run stopped by the watchdog after %0d cycles", cycles);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Done: errors found");
        $finish;
    end

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // One Wishbone classic single transfer
    task automatic transfer(input logic we, input logic [16:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic acked);
        int waits;
        waits = 0;
        acked = 1'b0;
        rdata = '0;
        @(posedge clk);
        #1;
        wb_req.adr = addr;
        wb_req.sel = 4'hF;
        wb_req.we  = we;
        wb_req.dat = wdata;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        while (!acked && waits < ACK_LIMIT)
        begin
            @(posedge clk);
            #1;
            waits++;
            if (wb_rsp.ack === 1'b1)
            begin
                acked = 1'b1;
                rdata = wb_rsp.dat;
            end
        end
        if (!acked)
        begin
            $display("No ack for address %h within %0d cycles", addr, ACK_LIMIT);
            errors++;
        end
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b0;   // Cycle after ack
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic poll_until(input logic [16:0] addr, input logic [31:0] value);
        int          start;
        logic [31:0] rd;
        logic        ok;
        logic        hit;
        start = cycles;
        hit   = 1'b0;
        while (!hit && cycles - start < WAIT_LIMIT)
        begin
            transfer(1'b0, addr, '0, rd, ok);
            hit = ok && rd === value;
        end
        if (!hit)
        begin
            $display("Address %h never read %h within %0d cycles", addr, value, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic wait_quiet(input int n);
        int start;
        int quiet;
        start = cycles;
        quiet = 0;
        while (quiet < n && cycles - start < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            quiet = (cs_n === 1'b1) ? quiet + 1 : 0;
        end
        if (quiet < n)
        begin
            $display("Sensor link did not go idle after capture was disabled");
            errors++;
        end
        link_may_run = 1'b0;
    endtask

    function automatic void add_step(input op_t op, input logic [16:0] addr,
                                     input logic [31:0] wdata, input logic [31:0] exp_val,
                                     input logic from_model);
        step_t s;
        s.op         = op;
        s.addr       = addr;
        s.wdata      = wdata;
        s.exp_val    = exp_val;
        s.from_model = from_model;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        add_step(OP_READ,  A_ID,        '0, 32'h0000_5E50, 1'b0);   // Fixed words
        add_step(OP_READ,  A_REV,       '0, 32'h0000_0100, 1'b0);
        add_step(OP_READ,  17'h121F8,   '0, 32'h0000_0100, 1'b0);
        add_step(OP_READ,  17'h121FC,   '0, 32'h0001_0000, 1'b0);
        add_step(OP_READ,  17'h00020,   '0, 32'hFABD_EFAC, 1'b0);
        add_step(OP_READ,  17'h12010,   '0, 32'hDEFF_ABAC, 1'b0);
        add_step(OP_WRITE, A_EN,        '0, '0, 1'b0);              // Capture off
        add_step(OP_READ,  A_EN,        '0, '0, 1'b0);
        add_step(OP_READ,  A_LEVEL,     '0, '0, 1'b0);
        add_step(OP_QUIET, '0,          40, '0, 1'b0);
        add_step(OP_READ,  A_LEVEL,     '0, '0, 1'b0);
        add_step(OP_WRITE, A_EN,        1,  '0, 1'b0);              // Three samples
        add_step(OP_READ,  A_EN,        '0, 1,  1'b0);
        add_step(OP_WAIT,  A_LEVEL,     '0, 3,  1'b0);
        add_step(OP_WRITE, A_EN,        '0, '0, 1'b0);
        for (int i = 0; i < 3; i++)
            add_step(OP_READ, A_DPORT, '0, '0, 1'b1);
        add_step(OP_WRITE, A_EN,        1,  '0, 1'b0);              // Run into overrun
        add_step(OP_WAIT,  A_OVR,       '0, 1,  1'b0);
        add_step(OP_WRITE, A_EN,        '0, '0, 1'b0);
        add_step(OP_QUIET, '0,          16, '0, 1'b0);
        add_step(OP_READ,  A_OVR,       '0, 1,  1'b0);
        add_step(OP_READ,  A_LEVEL,     '0, FIFO_DEPTH, 1'b0);
        for (int i = 0; i < FIFO_DEPTH; i++)
            add_step(OP_READ, A_DPORT, '0, '0, 1'b1);
        add_step(OP_WRITE, A_OVR,       1,  '0, 1'b0);
        add_step(OP_READ,  A_OVR,       '0, '0, 1'b0);
        add_step(OP_WRITE, A_EN,        1,  '0, 1'b0);              // Flush
        add_step(OP_WAIT,  A_LEVEL,     '0, 2,  1'b0);
        add_step(OP_WRITE, A_EN,        '0, '0, 1'b0);
        add_step(OP_QUIET, '0,          16, '0, 1'b0);
        add_step(OP_WRITE, A_FRST,      1,  '0, 1'b0);
        add_step(OP_READ,  A_LEVEL,     '0, '0, 1'b0);
        add_step(OP_READ,  A_DPORT,     '0, '0, 1'b0);
        add_step(OP_READ,  17'h08000,   '0, BAD_WORD, 1'b0);        // Unmapped
        add_step(OP_READ,  17'h1F004,   '0, BAD_WORD, 1'b0);
    endfunction

    task automatic apply_step(input step_t s);
        logic [31:0] rd;
        logic [31:0] want;
        logic        ok;
        want = s.exp_val;
        case (s.op)
            OP_READ:
            begin
                transfer(1'b0, s.addr, '0, rd, ok);
                if (s.from_model)
                begin
                    if (model_idx < sensor.word_log.size())
                        want = sensor.word_log[model_idx];
                    else
                    begin
                        $display("Sensor model sent fewer words than the data port returned");
                        errors++;
                        ok = 1'b0;
                    end
                    model_idx++;
                end
                if (ok)
                    compare_values($sformatf("wb_rsp_o.dat at %h", s.addr), rd, want);
            end
            OP_WRITE:
            begin
                if (s.addr == A_EN && s.wdata[0])
                    link_may_run = 1'b1;
                transfer(1'b1, s.addr, s.wdata, rd, ok);
            end
            OP_WAIT:
                poll_until(s.addr, s.exp_val);
            default:
                wait_quiet(int'(s.wdata));
        endcase
    endtask

    initial
    begin
        rst    = 1'b1;
        wb_req = '0;
        build_table();
        cycle_limit = steps.size() * WAIT_LIMIT;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (steps[i])
            apply_step(steps[i]);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: sensor_bridge.f
logic/sensor_bridge_pkg.sv
logic/spi_sample_reader.sv
logic/sample_fifo.sv
logic/wb_reg_bank.sv
logic/wb_addr_decode.sv
logic/sensor_bridge_top.sv
test/spi_sensor_model.sv
test/tb_sensor_bridge.sv

// File: Makefile
TB_TOP  = tb_sensor_bridge
RTL_TOP = sensor_bridge_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sensor_bridge.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --assert -f sensor_bridge.f --top-module $(TB_TOP) -Mdir obj_dir
	-./obj_dir/V$(TB_TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
